/* src.f */
hdl/periph_pkg.sv
hdl/wb_periph_router.sv
hdl/misc_regs.sv
hdl/pdm_decimator.sv
hdl/matrix_regs.sv
hdl/matrix_scanner.sv
hdl/periph_top.sv
verif/periph_tb.sv

/* Bender.yml */
package:
  name: periph_soc

sources:
  - hdl/periph_pkg.sv
  - hdl/wb_periph_router.sv
  - hdl/misc_regs.sv
  - hdl/pdm_decimator.sv
  - hdl/matrix_regs.sv
  - hdl/matrix_scanner.sv
  - hdl/periph_top.sv
  - target: simulation
    files:
      - verif/periph_tb.sv

/* verif/periph_tb.sv */
`timescale 1ns/10ps

module periph_tb import periph_pkg::*; ();

    localparam int SAMPLE_DEPTH = 6;
    localparam int MIC_DIV      = 2;
    localparam int MATRIX_COLS  = 8;
    localparam int COL_DWELL    = 16;

    localparam int          CLK_HALF      = 20;
    localparam int          DRIVE_DLY     = 2;
    localparam logic [31:0] SEED          = 32'h8b81;
    localparam int          XFER_LIMIT    = 8;
    localparam int          DWELL_CYCLES  = COL_DWELL - 1;
    localparam int          FRAME_WORDS   = MATRIX_BANKS * MATRIX_COLS;
    localparam int          FRAME_CYCLES  = FRAME_WORDS * COL_DWELL;
    localparam int          FULL_SCALE    = (1 << SAMPLE_DEPTH) - 1;
    localparam int          WINDOW_CYCLES = FULL_SCALE * 2 * MIC_DIV;
    // Upper bound on the bus transfers issued below
    localparam int          XFER_COUNT    = 90;
    localparam int          WATCHDOG_CYCLES =
        (XFER_COUNT * 3 + 3 * WINDOW_CYCLES + 2 * FRAME_CYCLES) * 5 / 4;

    localparam logic [15:0] LED_ADR   = {SLV_MISC, MISC_LED_OFS};
    localparam logic [15:0] BTN_ADR   = {SLV_MISC, MISC_BTN_OFS};
    localparam logic [15:0] AUDIO_ADR = {SLV_MISC, MISC_AUDIO_OFS};
    localparam logic [15:0] CTRL_ADR  = {SLV_DISPLAY, MATRIX_CTRL_OFS};
    localparam matrix_drive_t IDLE_DRIVE = '{bank: '0, row_data: '0, row_oe_n: 1'b1,
                                             col_first: 1'b0, col_advance: 1'b0};

    logic          clk_24mhz;
    logic          reset_i;
    wb_req_t       req;
    wb_rsp_t       rsp;
    logic [1:0]    buttons;
    logic [2:0]    leds;
    logic          mic_data;
    logic          mic_clk;
    matrix_drive_t matrix;
    logic          frame_complete;

    // Reference model of registers, frame memory and scan position
    logic [2:0]            led_model = '0;
    logic [ROW_DATA_W-1:0] frame_model [FRAME_WORDS];
    logic                  scan_on = 1'b0;
    int                    audio_model = 0;
    int                    step_cnt;
    int                    exp_col;
    int                    exp_bank;
    logic [ROW_DATA_W-1:0] exp_row;
    logic                  rd_check = 1'b0;
    logic [31:0]           exp_dat = '0;
    logic                  req_live;
    int                    value_errs = 0;
    int                    proto_errs = 0;

    periph_top #(
        .SAMPLE_DEPTH ( SAMPLE_DEPTH ),
        .MIC_DIV      ( MIC_DIV      ),
        .MATRIX_COLS  ( MATRIX_COLS  ),
        .COL_DWELL    ( COL_DWELL    )
    ) dut (
        .clk_24mhz        ( clk_24mhz      ),
        .reset_i          ( reset_i        ),
        .wb_req_i         ( req            ),
        .wb_rsp_o         ( rsp            ),
        .buttons_i        ( buttons        ),
        .leds_o           ( leds           ),
        .mic_data_i       ( mic_data       ),
        .mic_clk_o        ( mic_clk        ),
        .matrix_o         ( matrix         ),
        .frame_complete_o ( frame_complete )
    );

    initial begin
        clk_24mhz = 1'b0;
        forever #CLK_HALF clk_24mhz = ~clk_24mhz;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_24mhz);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Column steps since enable, bank-major
    always_ff @(posedge clk_24mhz) begin
        if (reset_i || !scan_on) begin
            step_cnt <= 0;
        end else if (matrix.col_advance) begin
            step_cnt <= step_cnt + 1;
        end
    end

    assign exp_col  = step_cnt % MATRIX_COLS;
    assign exp_bank = (step_cnt / MATRIX_COLS) % MATRIX_BANKS;
    assign exp_row  = frame_model[exp_bank * MATRIX_COLS + exp_col];
    assign req_live = req.cyc && req.stb;

    function automatic logic unmapped_slot(input logic [15:0] adr);
        return !(adr[15:12] == SLV_MISC || adr[15:12] == SLV_DISPLAY);
    endfunction

    function automatic logic [31:0] expected_read(input logic [15:0] adr);
        logic [OFFSET_W-1:0] ofs;
        ofs = adr[OFFSET_W-1:0];
        expected_read = '0;
        if (adr[15:12] == SLV_MISC) begin
            if (ofs == MISC_LED_OFS) expected_read = {29'd0, led_model};
            if (ofs == MISC_BTN_OFS) expected_read = {30'd0, buttons};
            if (ofs == MISC_AUDIO_OFS) expected_read = 32'(audio_model);
        end else if (adr[15:12] == SLV_DISPLAY) begin
            if (ofs < FRAME_WORDS) expected_read = {24'd0, frame_model[ofs]};
            if (ofs == MATRIX_CTRL_OFS) expected_read = {31'd0, scan_on};
        end
    endfunction

    // ------------------------------------------------------------------
    // Bus master

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_24mhz);
        #DRIVE_DLY;
    endtask

    // Raises the request and waits until ack or err shows up
    task automatic run_transfer(input logic we, input logic [15:0] adr,
                                input logic [31:0] dat, input logic [3:0] sel);
        int waited;
        waited = 0;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
        do begin
            @(posedge clk_24mhz);
            #DRIVE_DLY;
            waited++;
        end while (!(rsp.ack || rsp.err) && waited < XFER_LIMIT);
        if (!(rsp.ack || rsp.err)) begin
            proto_errs++;
            $display("no ack or err for address %h within %0d cycles", adr, XFER_LIMIT);
        end
    endtask

    // Request stays up through the edge that samples the response
    task automatic release_bus();
        wait_cycles(1);
        req = '0;
        wait_cycles(1);
    endtask

    task automatic write_word(input logic [15:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [OFFSET_W-1:0] ofs;
        ofs = adr[OFFSET_W-1:0];
        run_transfer(1'b1, adr, dat, sel);
        // Registers change on the edge that samples the request
        if (sel[0] && adr[15:12] == SLV_MISC && ofs == MISC_LED_OFS) begin
            led_model = dat[2:0];
        end else if (sel[0] && adr[15:12] == SLV_DISPLAY && ofs < FRAME_WORDS) begin
            frame_model[ofs] = dat[ROW_DATA_W-1:0];
        end else if (sel[0] && adr[15:12] == SLV_DISPLAY && ofs == MATRIX_CTRL_OFS) begin
            scan_on = dat[0];
        end
        release_bus();
    endtask

    task automatic read_word(input logic [15:0] adr);
        exp_dat  = expected_read(adr);
        rd_check = 1'b1;
        run_transfer(1'b0, adr, '0, 4'hF);
        release_bus();
        rd_check = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Bus checks

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        $rose(req_live) && !unmapped_slot(req.adr) |=> rsp.ack && !rsp.err)
    else begin
        proto_errs++;
        $display("mapped slave did not ack exactly one cycle after the request");
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        $rose(req_live) && unmapped_slot(req.adr) |=> rsp.err && !rsp.ack)
    else begin
        proto_errs++;
        $display("unmapped slot did not answer with err one cycle after the request");
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        (rsp.ack || rsp.err || !req_live) |=> !(rsp.ack || rsp.err))
    else begin
        proto_errs++;
        $display("response longer than one cycle or without a request");
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        rsp.ack && rd_check |-> rsp.dat == exp_dat)
    else begin
        value_errs++;
        $display("error: rsp.dat = %h, expected %h", $sampled(rsp.dat), $sampled(exp_dat));
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i) leds == led_model)
    else begin
        value_errs++;
        $display("error: leds_o = %h, expected %h", $sampled(leds), $sampled(led_model));
    end

    // ------------------------------------------------------------------
    // Microphone clock checks

    // First toggle comes MIC_DIV cycles after reset
    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        $fell(reset_i) |-> ##MIC_DIV $changed(mic_clk))
    else begin
        proto_errs++;
        $display("mic clock did not start toggling after reset");
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        $changed(mic_clk) |=> $stable(mic_clk)[*MIC_DIV-1] ##1 $changed(mic_clk))
    else begin
        proto_errs++;
        $display("mic clock level did not last exactly the divider period");
    end

    // ------------------------------------------------------------------
    // Scanner checks

    assert property (@(posedge clk_24mhz) disable iff (reset_i || !scan_on)
        matrix.col_advance |-> matrix.row_oe_n && matrix.row_data == exp_row
            && matrix.bank == MATRIX_BANKS'(1 << exp_bank)
            && matrix.col_first == (exp_col == 0))
    else begin
        value_errs++;
        $display("error: matrix_o = %h, expected bank %h col %h row_data %h",
                 $sampled(matrix), $sampled(exp_bank), $sampled(exp_col), $sampled(exp_row));
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i || !scan_on)
        matrix.col_advance |=> (!matrix.col_advance && !matrix.row_oe_n)[*DWELL_CYCLES]
            ##1 matrix.col_advance)
    else begin
        proto_errs++;
        $display("column advance and dwell cycles out of order");
    end

    assert property (@(posedge clk_24mhz) disable iff (reset_i || !scan_on)
        frame_complete == (matrix.col_advance && step_cnt != 0
                           && step_cnt % FRAME_WORDS == 0))
    else begin
        value_errs++;
        $display("error: frame_complete_o = %h at column step %h",
                 $sampled(frame_complete), $sampled(step_cnt));
    end

    // Enable takes one edge to reach the scanner, one more to go idle
    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        !scan_on && !$past(scan_on) && !$past(scan_on, 2)
            |-> matrix == IDLE_DRIVE && !frame_complete)
    else begin
        value_errs++;
        $display("error: matrix_o = %h, expected idle %h", $sampled(matrix), IDLE_DRIVE);
    end

    // ------------------------------------------------------------------
    // Stimulus

    initial begin
        logic [3:0] slot;
        void'($urandom(SEED));
        req      = '0;
        buttons  = 2'b00;
        mic_data = 1'b0;
        reset_i  = 1'b1;
        wait_cycles(2);
        reset_i = 1'b0;

        // LED register and its byte lane
        write_word(LED_ADR, 32'hFFFF_FFF5, 4'hF);
        read_word(LED_ADR);
        write_word(LED_ADR, 32'h0000_0002, 4'b1110);
        read_word(LED_ADR);

        // Buttons through the synchronizer, register is read-only
        buttons = 2'b10;
        wait_cycles(3);
        read_word(BTN_ADR);
        write_word(BTN_ADR, 32'h0000_0001, 4'hF);
        read_word(BTN_ADR);
        buttons = 2'b01;
        wait_cycles(3);
        read_word(BTN_ADR);

        // Former serial slot and random unmapped slots
        read_word(16'h1000);
        write_word(16'h1004, $urandom, 4'hF);
        for (int i = 0; i < 6; i++) begin
            slot = 4'(3 + $urandom_range(12));
            read_word({slot, 12'($urandom)});
        end

        // Frame memory with random upper bits
        for (int i = 0; i < FRAME_WORDS; i++) begin
            write_word({SLV_DISPLAY, 12'(i)}, $urandom, 4'hF);
        end
        for (int i = 0; i < FRAME_WORDS; i++) begin
            read_word({SLV_DISPLAY, 12'(i)});
        end

        // Two full frames of scanning
        write_word(CTRL_ADR, 32'h1, 4'hF);
        read_word(CTRL_ADR);
        wait_cycles(2 * FRAME_CYCLES + 8);
        write_word(CTRL_ADR, 32'h0, 4'hF);
        wait_cycles(4);
        read_word(CTRL_ADR);

        // Microphone held high, then low
        mic_data = 1'b1;
        wait_cycles(2 * WINDOW_CYCLES + 4);
        audio_model = FULL_SCALE;
        read_word(AUDIO_ADR);
        mic_data = 1'b0;
        wait_cycles(2 * WINDOW_CYCLES + 4);
        audio_model = 0;
        read_word(AUDIO_ADR);

        wait_cycles(4);
        $display("checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/periph_top.sv */
`timescale 1ns/10ps

module periph_top import periph_pkg::*; #(
    parameter int SAMPLE_DEPTH = 12,
    parameter int MIC_DIV      = 2,
    parameter int MATRIX_COLS  = 8,
    parameter int COL_DWELL    = 16
) (
    input  logic          clk_24mhz,
    input  logic          reset_i,
    input  wb_req_t       wb_req_i,
    output wb_rsp_t       wb_rsp_o,
    input  logic [1:0]    buttons_i,
    output logic [2:0]    leds_o,
    input  logic          mic_data_i,
    output logic          mic_clk_o,
    output matrix_drive_t matrix_o,
    output logic          frame_complete_o
);

    localparam int COL_W  = $clog2(MATRIX_COLS);
    localparam int BANK_W = $clog2(MATRIX_BANKS);

    wb_req_t                 misc_req;
    wb_rsp_t                 misc_rsp;
    wb_req_t                 disp_req;
    wb_rsp_t                 disp_rsp;
    logic [SAMPLE_DEPTH-1:0] audio;
    logic                    scan_enable;
    logic [BANK_W-1:0]       rd_bank;
    logic [COL_W-1:0]        rd_col;
    logic [ROW_DATA_W-1:0]   rd_data;

    // ------------------------------------------------------------------
    // Bus decode
    wb_periph_router router_inst (
        .clk_24mhz  ( clk_24mhz ),
        .reset_i    ( reset_i   ),
        .req_i      ( wb_req_i  ),
        .rsp_o      ( wb_rsp_o  ),
        .misc_req_o ( misc_req  ),
        .misc_rsp_i ( misc_rsp  ),
        .disp_req_o ( disp_req  ),
        .disp_rsp_i ( disp_rsp  )
    );

    // ------------------------------------------------------------------
    // Slot 0, LEDs, buttons and audio
    misc_regs #(
        .SAMPLE_DEPTH ( SAMPLE_DEPTH )
    ) misc_inst (
        .clk_24mhz ( clk_24mhz ),
        .reset_i   ( reset_i   ),
        .req_i     ( misc_req  ),
        .rsp_o     ( misc_rsp  ),
        .buttons_i ( buttons_i ),
        .audio_i   ( audio     ),
        .leds_o    ( leds_o    )
    );

    pdm_decimator #(
        .SAMPLE_DEPTH ( SAMPLE_DEPTH ),
        .MIC_DIV      ( MIC_DIV      )
    ) mic_inst (
        .clk_24mhz  ( clk_24mhz  ),
        .reset_i    ( reset_i    ),
        .mic_data_i ( mic_data_i ),
        .mic_clk_o  ( mic_clk_o  ),
        .audio_o    ( audio      )
    );

    // ------------------------------------------------------------------
    // Slot 2, LED matrix
    matrix_regs #(
        .MATRIX_COLS ( MATRIX_COLS )
    ) disp_regs_inst (
        .clk_24mhz ( clk_24mhz   ),
        .reset_i   ( reset_i     ),
        .req_i     ( disp_req    ),
        .rsp_o     ( disp_rsp    ),
        .enable_o  ( scan_enable ),
        .rd_bank_i ( rd_bank     ),
        .rd_col_i  ( rd_col      ),
        .rd_data_o ( rd_data     )
    );

    matrix_scanner #(
        .MATRIX_COLS ( MATRIX_COLS ),
        .COL_DWELL   ( COL_DWELL   )
    ) scanner_inst (
        .clk_24mhz        ( clk_24mhz        ),
        .reset_i          ( reset_i          ),
        .enable_i         ( scan_enable      ),
        .rd_bank_o        ( rd_bank          ),
        .rd_col_o         ( rd_col           ),
        .rd_data_i        ( rd_data          ),
        .matrix_o         ( matrix_o         ),
        .frame_complete_o ( frame_complete_o )
    );

endmodule

/* hdl/matrix_scanner.sv */
`timescale 1ns/10ps

module matrix_scanner import periph_pkg::*; #(
    parameter  int MATRIX_COLS = 8,
    parameter  int COL_DWELL   = 16,
    localparam int COL_W       = $clog2(MATRIX_COLS),
    localparam int BANK_W      = $clog2(MATRIX_BANKS)
) (
    input  logic                  clk_24mhz,
    input  logic                  reset_i,
    input  logic                  enable_i,
    output logic [BANK_W-1:0]     rd_bank_o,
    output logic [COL_W-1:0]      rd_col_o,
    input  logic [ROW_DATA_W-1:0] rd_data_i,
    output matrix_drive_t         matrix_o,
    output logic                  frame_complete_o
);

    localparam int DWELL_W = $clog2(COL_DWELL);
    // COL_DWELL - 1 dwell cycles per column, at least one
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(COL_DWELL - 2);

    scan_state_e        state_q;
    logic [BANK_W-1:0]  bank_q;
    logic [COL_W-1:0]   col_q;
    logic [DWELL_W-1:0] dwell_q;
    logic               last_col;
    logic               last_bank;
    logic               frame_q;

    assign last_col  = (col_q == COL_W'(MATRIX_COLS - 1));
    assign last_bank = (bank_q == BANK_W'(MATRIX_BANKS - 1));

    always_ff @(posedge clk_24mhz) begin
        if (reset_i || !enable_i) begin
            state_q <= SCAN_IDLE;
            bank_q  <= '0;
            col_q   <= '0;
            dwell_q <= '0;
            frame_q <= 1'b0;
        end else begin
            frame_q <= 1'b0;
            case (state_q)
                SCAN_IDLE: state_q <= SCAN_ADVANCE;
                SCAN_ADVANCE: begin
                    state_q <= SCAN_DWELL;
                    dwell_q <= '0;
                end
                SCAN_DWELL: begin
                    if (dwell_q == DWELL_LAST) begin
                        state_q <= SCAN_ADVANCE;
                        if (last_col) begin
                            col_q   <= '0;
                            bank_q  <= last_bank ? '0 : bank_q + 1'b1;
                            // Shows up in the advance cycle of bank 0, column 0
                            frame_q <= last_bank;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end else begin
                        dwell_q <= dwell_q + 1'b1;
                    end
                end
                default: state_q <= SCAN_IDLE;
            endcase
        end
    end

    assign rd_bank_o = bank_q;
    assign rd_col_o  = col_q;

    always_comb begin
        matrix_o          = '0;
        matrix_o.row_oe_n = (state_q != SCAN_DWELL);
        if (state_q != SCAN_IDLE) begin
            matrix_o.bank        = MATRIX_BANKS'(1) << bank_q;
            matrix_o.row_data    = rd_data_i;
            matrix_o.col_advance = (state_q == SCAN_ADVANCE);
            matrix_o.col_first   = (state_q == SCAN_ADVANCE) && (col_q == '0);
        end
    end

    assign frame_complete_o = frame_q;

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        (state_q != SCAN_IDLE) |-> $onehot(matrix_o.bank));

endmodule

/* hdl/matrix_regs.sv */
`timescale 1ns/10ps

module matrix_regs import periph_pkg::*; #(
    parameter  int MATRIX_COLS = 8,
    localparam int COL_W       = $clog2(MATRIX_COLS),
    localparam int BANK_W      = $clog2(MATRIX_BANKS)
) (
    input  logic                  clk_24mhz,
    input  logic                  reset_i,
    input  wb_req_t               req_i,
    output wb_rsp_t               rsp_o,
    output logic                  enable_o,
    input  logic [BANK_W-1:0]     rd_bank_i,
    input  logic [COL_W-1:0]      rd_col_i,
    output logic [ROW_DATA_W-1:0] rd_data_o
);

    localparam int FRAME_DEPTH = MATRIX_BANKS * MATRIX_COLS;
    localparam int FRAME_AW    = $clog2(FRAME_DEPTH);

    logic [ROW_DATA_W-1:0] frame_mem [FRAME_DEPTH];

    logic [OFFSET_W-1:0]  ofs;
    logic [FRAME_AW-1:0]  bus_idx;
    logic [FRAME_AW-1:0]  scan_idx;
    logic                 in_frame;
    logic                 access;
    logic                 ack_q;
    logic                 enable_q;
    logic [WB_DATA_W-1:0] rd_word;
    logic [WB_DATA_W-1:0] dat_q;

    assign ofs      = req_i.adr[OFFSET_W-1:0];
    assign bus_idx  = ofs[FRAME_AW-1:0];
    assign in_frame = (ofs < OFFSET_W'(FRAME_DEPTH));
    assign access   = req_i.cyc && req_i.stb && !ack_q;

    // Bank-major layout
    assign scan_idx  = FRAME_AW'(rd_bank_i) * FRAME_AW'(MATRIX_COLS) + FRAME_AW'(rd_col_i);
    assign rd_data_o = frame_mem[scan_idx];

    always_ff @(posedge clk_24mhz) begin
        if (access && req_i.we && req_i.sel[0] && in_frame) begin
            frame_mem[bus_idx] <= req_i.dat[ROW_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.sel[0] && ofs == MATRIX_CTRL_OFS) begin
                enable_q <= req_i.dat[0];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (in_frame) begin
            rd_word[ROW_DATA_W-1:0] = frame_mem[bus_idx];
        end else if (ofs == MATRIX_CTRL_OFS) begin
            rd_word[0] = enable_q;
        end
    end

    always_ff @(posedge clk_24mhz) begin
        if (access) begin
            dat_q <= rd_word;
        end
    end

    assign rsp_o    = '{ack: ack_q, err: 1'b0, dat: dat_q};
    assign enable_o = enable_q;

endmodule

/* hdl/pdm_decimator.sv */
`timescale 1ns/10ps

module pdm_decimator #(
    parameter int SAMPLE_DEPTH = 12,
    parameter int MIC_DIV      = 2
) (
    input  logic                    clk_24mhz,
    input  logic                    reset_i,
    input  logic                    mic_data_i,
    output logic                    mic_clk_o,
    output logic [SAMPLE_DEPTH-1:0] audio_o
);

    localparam int DIV_W = $clog2(MIC_DIV) + 1;
    // Window closes on sample number 2^SAMPLE_DEPTH - 1
    localparam logic [SAMPLE_DEPTH-1:0] LAST_SAMPLE = {{(SAMPLE_DEPTH-1){1'b1}}, 1'b0};

    logic [DIV_W-1:0]        div_cnt;
    logic                    mic_clk_q;
    logic                    div_wrap;
    logic                    mic_rise;
    logic [SAMPLE_DEPTH-1:0] sample_cnt;
    logic [SAMPLE_DEPTH-1:0] ones_cnt;

    assign div_wrap = (div_cnt == DIV_W'(MIC_DIV - 1));
    assign mic_rise = div_wrap && !mic_clk_q;

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            div_cnt    <= '0;
            mic_clk_q  <= 1'b0;
            sample_cnt <= '0;
            ones_cnt   <= '0;
            audio_o    <= '0;
        end else begin
            if (div_wrap) begin
                div_cnt   <= '0;
                mic_clk_q <= !mic_clk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            // Data is taken on the edge that raises the mic clock
            if (mic_rise) begin
                if (sample_cnt == LAST_SAMPLE) begin
                    audio_o    <= ones_cnt + SAMPLE_DEPTH'(mic_data_i);
                    ones_cnt   <= '0;
                    sample_cnt <= '0;
                end else begin
                    ones_cnt   <= ones_cnt + SAMPLE_DEPTH'(mic_data_i);
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

    assign mic_clk_o = mic_clk_q;

endmodule

/* hdl/misc_regs.sv */
`timescale 1ns/10ps

module misc_regs import periph_pkg::*; #(
    parameter int SAMPLE_DEPTH = 12
) (
    input  logic                    clk_24mhz,
    input  logic                    reset_i,
    input  wb_req_t                 req_i,
    output wb_rsp_t                 rsp_o,
    input  logic [1:0]              buttons_i,
    input  logic [SAMPLE_DEPTH-1:0] audio_i,
    output logic [2:0]              leds_o
);

    logic [OFFSET_W-1:0]  ofs;
    logic                 access;
    logic                 ack_q;
    logic [WB_DATA_W-1:0] rd_word;
    logic [WB_DATA_W-1:0] dat_q;
    logic [2:0]           leds_q;
    logic [1:0]           btn_meta_q;
    logic [1:0]           btn_sync_q;

    assign ofs    = req_i.adr[OFFSET_W-1:0];
    // No new access while the ack of the held request is out
    assign access = req_i.cyc && req_i.stb && !ack_q;

    // Two-flop synchronizer for the button pins
    always_ff @(posedge clk_24mhz) begin
        btn_meta_q <= buttons_i;
        btn_sync_q <= btn_meta_q;
    end

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            leds_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && req_i.sel[0] && ofs == MISC_LED_OFS) begin
                leds_q <= req_i.dat[2:0];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (ofs)
            MISC_LED_OFS:   rd_word[2:0] = leds_q;
            MISC_BTN_OFS:   rd_word[1:0] = btn_sync_q;
            MISC_AUDIO_OFS: rd_word[SAMPLE_DEPTH-1:0] = audio_i;
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_24mhz) begin
        if (access) begin
            dat_q <= rd_word;
        end
    end

    assign rsp_o  = '{ack: ack_q, err: 1'b0, dat: dat_q};
    assign leds_o = leds_q;

    // Held request must not produce a second ack
    assert property (@(posedge clk_24mhz) disable iff (reset_i) ack_q |=> !ack_q);

endmodule

/* hdl/wb_periph_router.sv */
`timescale 1ns/10ps

module wb_periph_router import periph_pkg::*; (
    input  logic    clk_24mhz,
    input  logic    reset_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o,
    output wb_req_t misc_req_o,
    input  wb_rsp_t misc_rsp_i,
    output wb_req_t disp_req_o,
    input  wb_rsp_t disp_rsp_i
);

    slave_sel_e slv;
    logic       slot_unmapped;
    logic       err_q;

    // Slave number sits in the top address bits
    assign slv = slave_sel_e'(req_i.adr[WB_ADDR_W-1 -: SLAVE_FIELD_W]);

    assign slot_unmapped = (slv == SLV_SERIAL) || (slv > SLV_DISPLAY);

    // Address, data, we and sel fan out to every slave
    always_comb begin
        misc_req_o     = req_i;
        misc_req_o.cyc = req_i.cyc && (slv == SLV_MISC);
        misc_req_o.stb = req_i.stb && (slv == SLV_MISC);
        disp_req_o     = req_i;
        disp_req_o.cyc = req_i.cyc && (slv == SLV_DISPLAY);
        disp_req_o.stb = req_i.stb && (slv == SLV_DISPLAY);
    end

    // One-cycle error, same timing as a slave ack
    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i.cyc && req_i.stb && slot_unmapped && !err_q;
        end
    end

    always_comb begin
        rsp_o = '0;
        case (slv)
            SLV_MISC:    rsp_o = misc_rsp_i;
            SLV_DISPLAY: rsp_o = disp_rsp_i;
            default:     rsp_o.err = err_q;
        endcase
    end

    // ------------------------------------------------------------------
    // Checks

    // Slave ack and router err come from different blocks
    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        !(rsp_o.ack && rsp_o.err));

    assert property (@(posedge clk_24mhz) disable iff (reset_i)
        $onehot0({misc_req_o.stb, disp_req_o.stb}));

endmodule

/* hdl/periph_pkg.sv */
package periph_pkg;

    // Peripheral port geometry
    localparam int WB_DATA_W     = 32;
    localparam int WB_SEL_W      = 4;
    localparam int WB_ADDR_W     = 16;
    localparam int SLAVE_FIELD_W = 4;
    localparam int OFFSET_W      = 12;

    // LED matrix geometry
    localparam int MATRIX_BANKS  = 4;
    localparam int ROW_DATA_W    = 8;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic [WB_SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic                 err;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [MATRIX_BANKS-1:0] bank;
        logic [ROW_DATA_W-1:0]   row_data;
        logic                    row_oe_n;
        logic                    col_first;
        logic                    col_advance;
    } matrix_drive_t;

    // Slot 1 was the USB serial port, now unmapped
    typedef enum logic [SLAVE_FIELD_W-1:0] {
        SLV_MISC    = 4'd0,
        SLV_SERIAL  = 4'd1,
        SLV_DISPLAY = 4'd2
    } slave_sel_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_ADVANCE,
        SCAN_DWELL
    } scan_state_e;

    // Register offsets, in words
    localparam logic [OFFSET_W-1:0] MISC_LED_OFS    = 12'd0;
    localparam logic [OFFSET_W-1:0] MISC_BTN_OFS    = 12'd1;
    localparam logic [OFFSET_W-1:0] MISC_AUDIO_OFS  = 12'd2;
    localparam logic [OFFSET_W-1:0] MATRIX_CTRL_OFS = 12'hFFF;

endpackage
